/* afu_emul_shell.f */
+incdir+hdl
hdl/emul_shell_pkg.sv
hdl/local_mem_bank.sv
hdl/mem_exerciser.sv
hdl/port_csr.sv
hdl/afu_emul_shell.sv
bench/afu_emul_shell_asserts.sv
bench/tb_afu_emul_shell.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_afu_emul_shell -f afu_emul_shell.f -o sim_afu_emul_shell

# A failed assertion must not stop the run before the closing report
./obj_dir/sim_afu_emul_shell +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "Simulation ok"
    exit 0
else
    echo "Simulation reported failure"
    exit 1
fi

/* bench/tb_afu_emul_shell.sv */
/* Drives the CSR port only, so bank contents are seen through exerciser error counts.
   A timeout ends the run at once */
`timescale 1ns/100ps
`include "emul_shell_macros.svh"

module tb_afu_emul_shell;

    localparam int NB          = `EMUL_NUM_BANKS;
    localparam int NP          = `EMUL_NUM_PORTS;
    localparam int TBL         = `EMUL_CSR_TABLE_BASE;
    localparam int ACK_TIMEOUT = 20;
    localparam int RUN_TIMEOUT = 1000;
    localparam int UNMAPPED [3] = '{4 * NB, TBL + NP, 'h3f};

    logic                    hssi_clk_pll = 1'b0;
    logic                    rst;
    emul_shell_pkg::wb_req_t wb_req;
    emul_shell_pkg::wb_rsp_t wb_rsp;

    logic [31:0] lfsr_state = 32'h9fd4_615d;
    int          error_cnt  = 0;
    int          check_cnt  = 0;
    int          bank_fails [NB];

    // Pending checks, pushed by the stimulus and drained by the compare process
    string       chk_name [$];
    logic [31:0] chk_exp  [$];
    logic [31:0] chk_act  [$];

    logic [31:0] run_seed   [NB];
    logic [31:0] stale_seed [NB];
    int          run_count  [NB];

    afu_emul_shell uut
    (
        .i_hssi_clk_pll (hssi_clk_pll),
        .i_rst          (rst),
        .i_wb           (wb_req),
        .o_wb           (wb_rsp)
    );

    always #2 hssi_clk_pll = ~hssi_clk_pll;

    // Assertion failure counts of the per-bank checkers
    for (genvar b = 0; b < NB; b++)
    begin : g_fails
        assign bank_fails[b] = uut.g_bank[b].u_mem.u_avmm_chk.fail_cnt;
    end

    // ========================================
    // Random source and reference model
    // ========================================

    // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Each bit taken costs one LFSR step
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Lane L of word A is seed ^ A ^ L
    function automatic logic [`EMUL_MEM_DATA_W-1:0] ref_pattern(input logic [31:0] seed,
                                                                input int addr);
        logic [`EMUL_MEM_DATA_W-1:0] w;
        w = '0;
        for (int l = 0; l < `EMUL_MEM_DATA_W / 32; l++)
            w[32*l +: 32] = seed ^ 32'(addr) ^ 32'(l);
        return w;
    endfunction

    // Words that read back wrong when the bank holds one seed and is checked with another
    function automatic int ref_errors(input logic [31:0] stored, input logic [31:0] checked,
                                      input int count);
        int n = 0;
        for (int a = 0; a < count; a++)
        begin
            if (ref_pattern(stored, a) != ref_pattern(checked, a))
                n++;
        end
        return n;
    endfunction

    function automatic logic [31:0] ref_status(input logic busy, input logic done,
                                               input int errs);
        return {16'(errs), 14'b0, done, busy};
    endfunction

    // pf_num 0, vf_num p in bits 13:3, vf_active in bit 14, link_num 0
    function automatic logic [31:0] ref_pf_vf(input int p);
        return (32'(p) << 3) | (32'd1 << 14);
    endfunction

    // ========================================
    // Compare process and reporting
    // ========================================

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        chk_name.push_back(name);
        chk_exp.push_back(exp);
        chk_act.push_back(act);
    endtask

    always @(posedge hssi_clk_pll)
    begin
        while (chk_act.size() > 0)
        begin
            check_cnt++;
            if (chk_act[0] !== chk_exp[0])
            begin
                error_cnt++;
                $display("Error: %s expected %h actual %h", chk_name[0], chk_exp[0],
                         chk_act[0]);
            end
            chk_name.delete(0);
            chk_exp.delete(0);
            chk_act.delete(0);
        end
    end

    task automatic finish_run();
        int afails;
        afails = uut.u_wb_chk.fail_cnt;
        for (int b = 0; b < NB; b++)
            afails += bank_fails[b];
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_cnt, error_cnt,
                 afails);
        if (error_cnt == 0 && afails == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    // ========================================
    // Wishbone host
    // ========================================

    // Drives on the rising edge, samples ack and data on the falling edge
    task automatic wb_access(input logic we, input int adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        emul_shell_pkg::wb_req_t r;
        int   waited;
        logic ack_seen;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.adr = emul_shell_pkg::csr_addr_t'(adr);
        r.dat = wdat;
        @(posedge hssi_clk_pll);
        wb_req <= r;
        waited = 0;
        do
        begin
            @(negedge hssi_clk_pll);
            waited++;
        end
        while (!wb_rsp.ack && waited < ACK_TIMEOUT);
        rdat     = wb_rsp.dat;
        ack_seen = wb_rsp.ack;
        @(posedge hssi_clk_pll);
        wb_req <= '0;
        if (!ack_seen)
        begin
            $display("Timeout: no Wishbone ack for CSR address %h", adr);
            error_cnt++;
            finish_run();
        end
    endtask

    task automatic start_run(input int b, input logic [31:0] seed, input int count,
                             input logic verify);
        logic [31:0] unused;
        wb_access(1'b1, 4*b + 1, seed, unused);
        wb_access(1'b1, 4*b + 2, 32'(count), unused);
        wb_access(1'b1, 4*b, {30'b0, verify, 1'b1}, unused);
    endtask

    // Polls the status word until done rises
    task automatic wait_done(input int b, output logic [31:0] stat);
        int polls;
        polls = 0;
        do
        begin
            wb_access(1'b0, 4*b + 3, 32'd0, stat);
            polls++;
        end
        while (!stat[1] && polls < RUN_TIMEOUT);
        if (!stat[1])
        begin
            $display("Timeout: bank %0d never reported done", b);
            error_cnt++;
            finish_run();
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        logic [31:0] rd;
        logic [31:0] v;
        int          waited;
        wb_req = '0;
        rst    = 1'b1;
        repeat (16) @(posedge hssi_clk_pll);
        rst <= 1'b0;

        // Every exerciser idle with a clear error count
        for (int b = 0; b < NB; b++)
        begin
            wb_access(1'b0, 4*b + 3, 32'd0, rd);
            expect_value($sformatf("reset_status_bank%0d", b), ref_status(0, 0, 0), rd);
        end

        for (int p = 0; p < NP; p++)
        begin
            wb_access(1'b0, TBL + p, 32'd0, rd);
            expect_value($sformatf("pf_vf_port%0d", p), ref_pf_vf(p), rd);
        end
        foreach (UNMAPPED[i])
        begin
            wb_access(1'b0, UNMAPPED[i], 32'd0, rd);
            expect_value($sformatf("unmapped_%h", UNMAPPED[i]), 32'd0, rd);
        end

        // All banks are started before any is polled so the runs overlap
        for (int b = 0; b < NB; b++)
        begin
            draw_bits(32, run_seed[b]);
            draw_bits(8, v);
            run_count[b] = int'(v) + 1;
            start_run(b, run_seed[b], run_count[b], 1'b0);
        end
        for (int b = 0; b < NB; b++)
        begin
            wait_done(b, rd);
            expect_value($sformatf("write_verify_bank%0d", b), ref_status(0, 1, 0), rd);
        end

        // Checking with a different seed flags every word written
        for (int b = 0; b < NB; b++)
        begin
            draw_bits(32, stale_seed[b]);
            if (stale_seed[b] == run_seed[b])
                stale_seed[b] = ~run_seed[b];
            start_run(b, stale_seed[b], run_count[b], 1'b1);
        end
        for (int b = 0; b < NB; b++)
        begin
            wait_done(b, rd);
            expect_value($sformatf("stale_pattern_bank%0d", b),
                         ref_status(0, 1, ref_errors(run_seed[b], stale_seed[b],
                                                     run_count[b])), rd);
        end

        // The original seed must still match, since verify_only never writes
        for (int b = 0; b < NB; b++)
            start_run(b, run_seed[b], run_count[b], 1'b1);
        for (int b = 0; b < NB; b++)
        begin
            wait_done(b, rd);
            expect_value($sformatf("retention_bank%0d", b),
                         ref_status(0, 1, ref_errors(run_seed[b], run_seed[b],
                                                     run_count[b])), rd);
        end

        waited = 0;
        while (chk_act.size() != 0 && waited < 10)
        begin
            @(posedge hssi_clk_pll);
            waited++;
        end
        if (chk_act.size() != 0)
        begin
            $display("Compare queue still held %0d checks at the end", chk_act.size());
            error_cnt++;
        end
        finish_run();
    end

endmodule

/* bench/afu_emul_shell_asserts.sv */
/* Handshake checker, bound once to the shell top for Wishbone and once per bank for Avalon.
   Bus inputs that a binding does not use are tied to zero */
`timescale 1ns/100ps

module afu_emul_shell_asserts
(
    input logic                      i_clk,
    input logic                      i_rst,
    input emul_shell_pkg::wb_req_t   i_wb,
    input emul_shell_pkg::wb_rsp_t   i_wb_rsp,
    input emul_shell_pkg::avmm_req_t i_req,
    input emul_shell_pkg::avmm_rsp_t i_rsp
);

    // Failed assertions, summed by the testbench at the end of a run
    int fail_cnt = 0;

    // ========================================
    // Wishbone rules
    // ========================================

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_rsp.ack |=> !i_wb_rsp.ack)
    else
    begin
        $error("Wishbone ack held for more than one cycle");
        fail_cnt++;
    end

    // Ack answers a strobe seen in the previous cycle
    ack_after_stb: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_rsp.ack |-> $past(i_wb.cyc && i_wb.stb))
    else
    begin
        $error("Wishbone ack without a preceding strobe");
        fail_cnt++;
    end

    // ========================================
    // Avalon rules
    // ========================================

    // A stalled request must not change until it is accepted
    req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_req.read || i_req.write) && i_rsp.waitrequest |=> $stable(i_req))
    else
    begin
        $error("Avalon request changed while waitrequest was high");
        fail_cnt++;
    end

    rd_wr_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_req.read && i_req.write))
    else
    begin
        $error("Avalon read and write asserted together");
        fail_cnt++;
    end

endmodule

bind afu_emul_shell afu_emul_shell_asserts u_wb_chk
(
    .i_clk    (i_hssi_clk_pll),
    .i_rst    (i_rst),
    .i_wb     (i_wb),
    .i_wb_rsp (o_wb),
    .i_req    ('0),
    .i_rsp    ('0)
);

bind local_mem_bank afu_emul_shell_asserts u_avmm_chk
(
    .i_clk    (i_hssi_clk_pll),
    .i_rst    (i_rst),
    .i_wb     ('0),
    .i_wb_rsp ('0),
    .i_req    (i_req),
    .i_rsp    (o_rsp)
);

/* hdl/afu_emul_shell.sv */
/* Emulation shell top, one clock and one synchronous reset for everything.
   Only the CSR port is visible; each exerciser owns its bank */
`timescale 1ns/100ps
`include "emul_shell_macros.svh"

module afu_emul_shell
(
    input  logic                    i_hssi_clk_pll,
    input  logic                    i_rst,
    input  emul_shell_pkg::wb_req_t i_wb,
    output emul_shell_pkg::wb_rsp_t o_wb
);

    // ========================================
    // Per-bank wiring
    // ========================================

    emul_shell_pkg::xcfg_t     cfg  [`EMUL_NUM_BANKS];
    emul_shell_pkg::xstat_t    stat [`EMUL_NUM_BANKS];
    emul_shell_pkg::avmm_req_t req  [`EMUL_NUM_BANKS];
    emul_shell_pkg::avmm_rsp_t rsp  [`EMUL_NUM_BANKS];

    // Host register block, also holds the PF/VF table
    port_csr u_csr
    (
        .i_hssi_clk_pll (i_hssi_clk_pll),
        .i_rst          (i_rst),
        .i_wb           (i_wb),
        .o_wb           (o_wb),
        .o_cfg          (cfg),
        .i_stat         (stat)
    );

    // One exerciser drives one bank, no sharing between channels
    for (genvar b = 0; b < `EMUL_NUM_BANKS; b++)
    begin : g_bank
        mem_exerciser u_xer
        (
            .i_hssi_clk_pll (i_hssi_clk_pll),
            .i_rst          (i_rst),
            .i_cfg          (cfg[b]),
            .o_stat         (stat[b]),
            .o_req          (req[b]),
            .i_rsp          (rsp[b])
        );

        local_mem_bank u_mem
        (
            .i_hssi_clk_pll (i_hssi_clk_pll),
            .i_rst          (i_rst),
            .i_req          (req[b]),
            .o_rsp          (rsp[b])
        );
    end

endmodule

/* hdl/port_csr.sv */
/* Wishbone classic CSR slave with no wait states; ack follows stb by one cycle.
   Unmapped words read zero and writes to them are dropped */
`timescale 1ns/100ps
`include "emul_shell_macros.svh"

module port_csr
(
    input  logic                   i_hssi_clk_pll,
    input  logic                   i_rst,
    input  emul_shell_pkg::wb_req_t i_wb,
    output emul_shell_pkg::wb_rsp_t o_wb,
    output emul_shell_pkg::xcfg_t  o_cfg [`EMUL_NUM_BANKS],
    input  emul_shell_pkg::xstat_t i_stat [`EMUL_NUM_BANKS]
);

    localparam int NB = `EMUL_NUM_BANKS;
    localparam int NP = `EMUL_NUM_PORTS;

    // ========================================
    // PF/VF table
    // ========================================

    typedef emul_shell_pkg::pf_vf_info_t [NP-1:0] pf_vf_map_t;

    // All ports are VFs of PF 0, VF number equal to port number
    function automatic pf_vf_map_t gen_pf_vf_map();
        pf_vf_map_t map;
        for (int p = 0; p < NP; p++)
        begin
            map[p].pf_num    = 3'd0;
            map[p].vf_num    = 11'(p);
            map[p].vf_active = 1'b1;
            map[p].link_num  = 1'b0;
        end
        return map;
    endfunction

    localparam pf_vf_map_t PORT_PF_VF_INFO = gen_pf_vf_map();

    // ========================================
    // Register file
    // ========================================

    logic                      ack_q;
    emul_shell_pkg::csr_data_t rd_q;
    emul_shell_pkg::csr_data_t rd_mux;
    logic                      strobe;
    logic                      wr_en;

    logic [NB-1:0]             verify_q;
    // arm_q rises with ack, start_q follows it one cycle later
    logic [NB-1:0]             arm_q;
    logic [NB-1:0]             start_q;
    emul_shell_pkg::csr_data_t seed_q  [NB];
    logic [`EMUL_CNT_W-1:0]    count_q [NB];

    // A new access is one that has not been acked yet
    assign strobe = i_wb.cyc && i_wb.stb && !ack_q;
    assign wr_en  = strobe && i_wb.we;

    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (i_rst)
        begin
            ack_q    <= 1'b0;
            verify_q <= '0;
            arm_q    <= '0;
            start_q  <= '0;
            for (int b = 0; b < NB; b++)
            begin
                seed_q[b]  <= '0;
                count_q[b] <= '0;
            end
        end
        else
        begin
            ack_q   <= strobe;
            start_q <= arm_q;
            arm_q   <= '0;
            for (int b = 0; b < NB; b++)
            begin
                if (wr_en && i_wb.adr == emul_shell_pkg::csr_addr_t'(4*b))
                begin
                    arm_q[b]    <= i_wb.dat[0];
                    verify_q[b] <= i_wb.dat[1];
                end
                if (wr_en && i_wb.adr == emul_shell_pkg::csr_addr_t'(4*b + 1))
                    seed_q[b] <= i_wb.dat;
                if (wr_en && i_wb.adr == emul_shell_pkg::csr_addr_t'(4*b + 2))
                    count_q[b] <= i_wb.dat[`EMUL_CNT_W-1:0];
            end
        end
    end

    // Read decode, start is self-clearing and always reads back as 0
    always_comb
    begin
        rd_mux = '0;
        for (int b = 0; b < NB; b++)
        begin
            if (i_wb.adr == emul_shell_pkg::csr_addr_t'(4*b))
                rd_mux = {30'b0, verify_q[b], 1'b0};
            if (i_wb.adr == emul_shell_pkg::csr_addr_t'(4*b + 1))
                rd_mux = seed_q[b];
            if (i_wb.adr == emul_shell_pkg::csr_addr_t'(4*b + 2))
                rd_mux = emul_shell_pkg::csr_data_t'(count_q[b]);
            if (i_wb.adr == emul_shell_pkg::csr_addr_t'(4*b + 3))
                rd_mux = {i_stat[b].err_count, 14'b0, i_stat[b].done, i_stat[b].busy};
        end
        for (int p = 0; p < NP; p++)
        begin
            if (i_wb.adr == emul_shell_pkg::csr_addr_t'(`EMUL_CSR_TABLE_BASE + p))
                rd_mux = emul_shell_pkg::csr_data_t'(PORT_PF_VF_INFO[p]);
        end
    end

    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (strobe)
            rd_q <= rd_mux;
    end

    always_comb
    begin
        o_wb.ack = ack_q;
        o_wb.dat = rd_q;
        for (int b = 0; b < NB; b++)
        begin
            o_cfg[b].start       = start_q[b];
            o_cfg[b].verify_only = verify_q[b];
            o_cfg[b].seed        = seed_q[b];
            o_cfg[b].count       = count_q[b];
        end
    end

endmodule

/* hdl/mem_exerciser.sv */
/* Write then read-back engine for one bank, always starting at word 0. A start while
   busy is ignored; a count of zero finishes at once with no traffic */
`timescale 1ns/100ps
`include "emul_shell_macros.svh"

module mem_exerciser
(
    input  logic                      i_hssi_clk_pll,
    input  logic                      i_rst,
    input  emul_shell_pkg::xcfg_t     i_cfg,
    output emul_shell_pkg::xstat_t    o_stat,
    output emul_shell_pkg::avmm_req_t o_req,
    input  emul_shell_pkg::avmm_rsp_t i_rsp
);

    emul_shell_pkg::xstate_e state;

    // Issue side counts accepted requests, response side counts returned words
    logic [`EMUL_CNT_W-1:0] issue_cnt;
    logic [`EMUL_CNT_W-1:0] rsp_cnt;
    logic [15:0]            err_q;

    // Run parameters captured at start
    emul_shell_pkg::csr_data_t seed_q;
    logic [`EMUL_CNT_W-1:0]    count_q;

    logic start_go;
    logic wr_acc;
    logic rd_acc;
    logic mismatch;

    // Lane L of the word at address A holds seed ^ A ^ L
    function automatic emul_shell_pkg::mem_data_t pattern(
        input emul_shell_pkg::csr_data_t seed,
        input emul_shell_pkg::mem_addr_t addr
    );
        emul_shell_pkg::mem_data_t word;
        word = '0;
        for (int l = 0; l < `EMUL_MEM_DATA_W / 32; l++)
            word[32*l +: 32] = seed ^ 32'(addr) ^ 32'(l);
        return word;
    endfunction

    assign start_go = i_cfg.start && (state == emul_shell_pkg::IDLE || state == emul_shell_pkg::DONE);
    assign wr_acc   = o_req.write && !i_rsp.waitrequest;
    assign rd_acc   = o_req.read && !i_rsp.waitrequest;
    assign mismatch = i_rsp.readdata !=
                      pattern(seed_q, emul_shell_pkg::mem_addr_t'(rsp_cnt));

    // ========================================
    // Request generation
    // ========================================

    // Built from registers only, so the request holds steady under waitrequest
    always_comb
    begin
        o_req.write      = (state == emul_shell_pkg::WRITE);
        o_req.read       = (state == emul_shell_pkg::READ) && (issue_cnt != count_q);
        o_req.address    = emul_shell_pkg::mem_addr_t'(issue_cnt);
        o_req.writedata  = pattern(seed_q, emul_shell_pkg::mem_addr_t'(issue_cnt));
        o_req.byteenable = '1;
    end

    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (start_go)
        begin
            seed_q  <= i_cfg.seed;
            count_q <= i_cfg.count;
        end
    end

    // ========================================
    // Run FSM
    // ========================================

    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (i_rst)
        begin
            state     <= emul_shell_pkg::IDLE;
            issue_cnt <= '0;
            rsp_cnt   <= '0;
            err_q     <= '0;
        end
        else
        begin
            case (state)
                emul_shell_pkg::IDLE,
                emul_shell_pkg::DONE:
                begin
                    if (start_go)
                    begin
                        issue_cnt <= '0;
                        rsp_cnt   <= '0;
                        err_q     <= '0;
                        if (i_cfg.count == '0)
                            state <= emul_shell_pkg::DONE;
                        else if (i_cfg.verify_only)
                            state <= emul_shell_pkg::READ;
                        else
                            state <= emul_shell_pkg::WRITE;
                    end
                end
                emul_shell_pkg::WRITE:
                begin
                    if (wr_acc)
                    begin
                        // Last write sends the issue counter back to word 0 for reads
                        if (issue_cnt + 1'b1 == count_q)
                        begin
                            issue_cnt <= '0;
                            state     <= emul_shell_pkg::READ;
                        end
                        else
                            issue_cnt <= issue_cnt + 1'b1;
                    end
                end
                emul_shell_pkg::READ:
                begin
                    // Reads go out without waiting for data
                    if (rd_acc)
                        issue_cnt <= issue_cnt + 1'b1;
                    if (i_rsp.readdatavalid)
                    begin
                        rsp_cnt <= rsp_cnt + 1'b1;
                        // Error count saturates instead of wrapping
                        if (mismatch && err_q != 16'hffff)
                            err_q <= err_q + 1'b1;
                        if (rsp_cnt + 1'b1 == count_q)
                            state <= emul_shell_pkg::DONE;
                    end
                end
                default:
                    state <= emul_shell_pkg::IDLE;
            endcase
        end
    end

    always_comb
    begin
        o_stat.busy      = (state == emul_shell_pkg::WRITE) || (state == emul_shell_pkg::READ);
        o_stat.done      = (state == emul_shell_pkg::DONE);
        o_stat.err_count = err_q;
    end

endmodule

/* hdl/local_mem_bank.sv */
/* Emulated bank with no bursts and no ECC. Reads return in order after EMUL_READ_LATENCY
   cycles; every accepted write stalls the port for one cycle */
`timescale 1ns/100ps
`include "emul_shell_macros.svh"

module local_mem_bank
(
    input  logic                     i_hssi_clk_pll,
    input  logic                     i_rst,
    input  emul_shell_pkg::avmm_req_t i_req,
    output emul_shell_pkg::avmm_rsp_t o_rsp
);

    localparam int DEPTH = 2 ** `EMUL_MEM_ADDR_W;
    localparam int LAT   = `EMUL_READ_LATENCY;

    emul_shell_pkg::mem_data_t mem [DEPTH];

    // Read return pipeline, stage LAT-1 drives the response
    logic [LAT-1:0]            vld_pipe;
    emul_shell_pkg::mem_data_t dat_pipe [LAT];

    // Emulates a controller that is briefly busy after each write
    logic wait_q;
    logic wr_acc;
    logic rd_acc;

    assign wr_acc = i_req.write && !wait_q;
    assign rd_acc = i_req.read && !wait_q;

    // ========================================
    // Storage
    // ========================================

    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (wr_acc)
        begin
            // Only the enabled bytes of the word change
            for (int i = 0; i < `EMUL_MEM_DATA_W / 8; i++)
            begin
                if (i_req.byteenable[i])
                    mem[i_req.address][8*i +: 8] <= i_req.writedata[8*i +: 8];
            end
        end
    end

    // Data stages shift every cycle, the valid flag tells which ones matter
    always_ff @(posedge i_hssi_clk_pll)
    begin
        dat_pipe[0] <= mem[i_req.address];
        for (int k = 1; k < LAT; k++)
            dat_pipe[k] <= dat_pipe[k-1];
    end

    // ========================================
    // Handshake control
    // ========================================

    always_ff @(posedge i_hssi_clk_pll)
    begin
        if (i_rst)
        begin
            wait_q   <= 1'b0;
            vld_pipe <= '0;
        end
        else
        begin
            // High for exactly the cycle after an accepted write
            wait_q      <= wr_acc;
            vld_pipe[0] <= rd_acc;
            for (int k = 1; k < LAT; k++)
                vld_pipe[k] <= vld_pipe[k-1];
        end
    end

    always_comb
    begin
        o_rsp.waitrequest   = wait_q;
        o_rsp.readdatavalid = vld_pipe[LAT-1];
        o_rsp.readdata      = dat_pipe[LAT-1];
    end

endmodule

/* hdl/emul_shell_pkg.sv */
/* Shared types of the shell; every width follows the macros header.
   Struct fields are packed MSB first, so the PF/VF entry maps straight onto CSR bits */
`include "emul_shell_macros.svh"

package emul_shell_pkg;

    // ========================================
    // Plain vector types
    // ========================================

    typedef logic [`EMUL_MEM_ADDR_W-1:0]   mem_addr_t;
    typedef logic [`EMUL_MEM_DATA_W-1:0]   mem_data_t;
    // One enable per data byte
    typedef logic [`EMUL_MEM_DATA_W/8-1:0] mem_be_t;
    typedef logic [`EMUL_CSR_ADDR_W-1:0]   csr_addr_t;
    typedef logic [31:0]                   csr_data_t;

    // ========================================
    // Bus structs
    // ========================================

    // Avalon-MM request, burst count is always one
    typedef struct packed {
        logic      read;
        logic      write;
        mem_addr_t address;
        mem_data_t writedata;
        mem_be_t   byteenable;
    } avmm_req_t;

    typedef struct packed {
        logic      waitrequest;
        logic      readdatavalid;
        mem_data_t readdata;
    } avmm_rsp_t;

    // Wishbone classic, host side
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        csr_addr_t adr;
        csr_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic      ack;
        csr_data_t dat;
    } wb_rsp_t;

    // Lands on CSR bits 15:0 with pf_num in the low bits
    typedef struct packed {
        logic        link_num;
        logic        vf_active;
        logic [10:0] vf_num;
        logic [2:0]  pf_num;
    } pf_vf_info_t;

    // ========================================
    // Exerciser control and status
    // ========================================

    typedef struct packed {
        logic                   start;
        logic                   verify_only;
        csr_data_t              seed;
        logic [`EMUL_CNT_W-1:0] count;
    } xcfg_t;

    typedef struct packed {
        logic        busy;
        logic        done;
        logic [15:0] err_count;
    } xstat_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ,
        DONE
    } xstate_e;

endpackage

/* hdl/emul_shell_macros.svh */
/* Build-time sizes of the emulation shell. EMUL_MEM_DATA_W must be a multiple of 32
   and EMUL_READ_LATENCY at least 1; the CSR map assumes at most 8 banks */
`ifndef EMUL_SHELL_MACROS_SVH
`define EMUL_SHELL_MACROS_SVH

// ========================================
// Topology
// ========================================

// Memory banks, each paired with one exerciser
`define EMUL_NUM_BANKS 2
// Accelerator ports listed in the PF/VF table
`define EMUL_NUM_PORTS 4

// ========================================
// Widths and timing
// ========================================

// Word address width of one bank
`define EMUL_MEM_ADDR_W 8
`define EMUL_MEM_DATA_W 64
// Word count field, wide enough to hold a full bank
`define EMUL_CNT_W (`EMUL_MEM_ADDR_W + 1)
// Cycles from an accepted read to readdatavalid
`define EMUL_READ_LATENCY 3
`define EMUL_CSR_ADDR_W 6
// First CSR word of the PF/VF table
`define EMUL_CSR_TABLE_BASE 'h20

`endif
